// ==== project.f ====
rtl/dcachePkg.sv
rtl/cacheCtrlFsm.sv
rtl/refillCollector.sv
rtl/tagStore.sv
rtl/dataStore.sv
rtl/dcacheTop.sv
tests/dcache_assertions.sv
tests/dcacheTb.sv

// ==== rtl/cacheCtrlFsm.sv ====
module cacheCtrlFsm (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   reqValid_i,
  input  logic                   hit_i,
  input  logic                   victimDirty_i,
  input  logic                   lastBeat_i,
  output dcachePkg::cacheState_e state_o,
  output logic                   respValid_o,
  output logic                   memRdReq_o,
  output logic                   memWrReq_o,
  output logic                   fillEn_o
);

  import dcachePkg::*;

  cacheState_e stateQ;
  cacheState_e stateNext;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= Idle;
    end else begin
      stateQ <= stateNext;
    end
  end

  always_comb begin
    stateNext = stateQ;
    case (stateQ)
      Idle: begin
        // requests are only taken here
        if (reqValid_i) begin
          stateNext = Lookup;
        end
      end
      Lookup: begin
        if (hit_i) begin
          stateNext = Idle;
        end else if (victimDirty_i) begin
          // old line has to leave before the refill
          stateNext = WriteBack;
        end else begin
          stateNext = MemRead;
        end
      end
      WriteBack: begin
        stateNext = MemRead;
      end
      MemRead: begin
        stateNext = Refill;
      end
      Refill: begin
        // beat count is kept by the collector
        if (lastBeat_i) begin
          stateNext = Fill;
        end
      end
      Fill: begin
        // second lookup now hits and answers
        stateNext = Lookup;
      end
      default: begin
        stateNext = Idle;
      end
    endcase
  end

  assign state_o = stateQ;

  // strobes decoded from the current state
  assign respValid_o = (stateQ == Lookup) && hit_i;
  assign memWrReq_o  = (stateQ == WriteBack);
  assign memRdReq_o  = (stateQ == MemRead);
  assign fillEn_o    = (stateQ == Fill);

endmodule

// ==== rtl/dataStore.sv ====
module dataStore #(
  parameter int IndexWidth = 6
) (
  input  logic                            clk,
  input  dcachePkg::reqAddr_u             addr_i,
  input  logic                            hitWay_i,
  input  logic                            victimWay_i,
  input  logic                            storeHit_i,
  input  logic                            fillEn_i,
  input  logic [dcachePkg::WordWidth-1:0] storeData_i,
  input  logic [dcachePkg::MaskWidth-1:0] storeMask_i,
  input  logic [dcachePkg::LineWidth-1:0] fillLine_i,
  output logic [dcachePkg::WordWidth-1:0] rdWord_o,
  output logic [dcachePkg::LineWidth-1:0] victimLine_o
);

  import dcachePkg::*;

  localparam int Sets         = 2 ** IndexWidth;
  localparam int WordSelWidth = $clog2(LineWords);

  logic [LineWords-1:0][WordWidth-1:0] lineArr [2][Sets];

  logic [IndexWidth-1:0]   idx;
  logic [WordSelWidth-1:0] wordSel;

  assign idx     = addr_i.fields.index;
  // upper offset bits pick the word, byte bits are ignored
  assign wordSel = addr_i.fields.offset[OffsetWidth-1 -: WordSelWidth];

  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      lineArr[victimWay_i][idx] <= fillLine_i;
    end else if (storeHit_i) begin
      // only enabled byte lanes change
      for (int b = 0; b < MaskWidth; b++) begin
        if (storeMask_i[b]) begin
          lineArr[hitWay_i][idx][wordSel][b*8 +: 8] <= storeData_i[b*8 +: 8];
        end
      end
    end
  end

  assign rdWord_o     = lineArr[hitWay_i][idx][wordSel];
  assign victimLine_o = lineArr[victimWay_i][idx];

endmodule

// ==== rtl/dcachePkg.sv ====
package dcachePkg;

  // bus and line geometry
  parameter int AddrWidth   = 32;
  parameter int WordWidth   = 64;
  parameter int MaskWidth   = WordWidth / 8;
  parameter int LineWords   = 4;
  parameter int LineWidth   = LineWords * WordWidth;
  parameter int OffsetWidth = 5;

  // index width the tag field is sized for
  parameter int IndexBits = 6;
  parameter int TagWidth  = AddrWidth - IndexBits - OffsetWidth;

  // controller states
  typedef enum logic [2:0] {
    Idle      = 3'd0,
    Lookup    = 3'd1,
    WriteBack = 3'd2,
    MemRead   = 3'd3,
    Refill    = 3'd4,
    Fill      = 3'd5
  } cacheState_e;

  // field view of a request address
  typedef struct packed {
    logic [TagWidth-1:0]    tag;
    logic [IndexBits-1:0]   index;
    logic [OffsetWidth-1:0] offset;
  } reqFields_t;

  // raw word or decoded fields, same 32 bits
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    reqFields_t           fields;
  } reqAddr_u;

endpackage

// ==== rtl/dcacheTop.sv ====
module dcacheTop #(
  parameter int IndexWidth = 6
) (
  input  logic                            clk,
  input  logic                            rst_n,
  // requester side
  input  logic                            reqValid_i,
  input  logic                            reqWrite_i,
  input  logic [dcachePkg::AddrWidth-1:0] reqAddr_i,
  input  logic [dcachePkg::WordWidth-1:0] reqWData_i,
  input  logic [dcachePkg::MaskWidth-1:0] reqWMask_i,
  output logic                            respValid_o,
  output logic [dcachePkg::WordWidth-1:0] respRData_o,
  // memory side
  output logic                            memRdReq_o,
  output logic [dcachePkg::AddrWidth-1:0] memRdAddr_o,
  input  logic                            memRdValid_i,
  input  logic [dcachePkg::WordWidth-1:0] memRdData_i,
  output logic                            memWrReq_o,
  output logic [dcachePkg::AddrWidth-1:0] memWrAddr_o,
  output logic [dcachePkg::LineWidth-1:0] memWrLine_o
);

  import dcachePkg::*;

  cacheState_e          state;
  reqAddr_u             reqAddrQ;
  reqAddr_u             lineAddr;
  logic                 reqWriteQ;
  logic [WordWidth-1:0] reqWDataQ;
  logic [MaskWidth-1:0] reqWMaskQ;

  logic                 accept;
  logic                 lookupEn;
  logic                 hit;
  logic                 hitWay;
  logic                 victimWay;
  logic                 victimDirty;
  logic                 storeHit;
  logic                 fillEn;
  logic                 lastBeat;
  logic [LineWidth-1:0] refillLine;

  assign accept = reqValid_i && (state == Idle);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqWriteQ <= 1'b0;
    end else if (accept) begin
      reqWriteQ <= reqWrite_i;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddrQ.raw <= reqAddr_i;
      reqWDataQ    <= reqWData_i;
      reqWMaskQ    <= reqWMask_i;
    end
  end

  assign lookupEn = (state == Lookup);
  // a store miss merges on the lookup after the fill
  assign storeHit = lookupEn && hit && reqWriteQ;

  always_comb begin
    lineAddr               = reqAddrQ;
    lineAddr.fields.offset = '0;
  end
  assign memRdAddr_o = lineAddr.raw;

  cacheCtrlFsm i_cacheCtrlFsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid_i),
    .hit_i         (hit),
    .victimDirty_i (victimDirty),
    .lastBeat_i    (lastBeat),
    .state_o       (state),
    .respValid_o   (respValid_o),
    .memRdReq_o    (memRdReq_o),
    .memWrReq_o    (memWrReq_o),
    .fillEn_o      (fillEn)
  );

  refillCollector i_refillCollector (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear_i     (memRdReq_o),
    .beatValid_i (memRdValid_i),
    .beatData_i  (memRdData_i),
    .lastBeat_o  (lastBeat),
    .line_o      (refillLine)
  );

  tagStore #(
    .IndexWidth (IndexWidth)
  ) i_tagStore (
    .clk           (clk),
    .rst_n         (rst_n),
    .addr_i        (reqAddrQ),
    .lookupEn_i    (lookupEn),
    .storeHit_i    (storeHit),
    .fillEn_i      (fillEn),
    .hit_o         (hit),
    .hitWay_o      (hitWay),
    .victimWay_o   (victimWay),
    .victimDirty_o (victimDirty),
    .victimAddr_o  (memWrAddr_o)
  );

  dataStore #(
    .IndexWidth (IndexWidth)
  ) i_dataStore (
    .clk          (clk),
    .addr_i       (reqAddrQ),
    .hitWay_i     (hitWay),
    .victimWay_i  (victimWay),
    .storeHit_i   (storeHit),
    .fillEn_i     (fillEn),
    .storeData_i  (reqWDataQ),
    .storeMask_i  (reqWMaskQ),
    .fillLine_i   (refillLine),
    .rdWord_o     (respRData_o),
    .victimLine_o (memWrLine_o)
  );

endmodule

// ==== rtl/refillCollector.sv ====
module refillCollector (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            clear_i,
  input  logic                            beatValid_i,
  input  logic [dcachePkg::WordWidth-1:0] beatData_i,
  output logic                            lastBeat_o,
  output logic [dcachePkg::LineWidth-1:0] line_o
);

  import dcachePkg::*;

  localparam int CntWidth = $clog2(LineWords);

  logic [CntWidth-1:0]                 beatCnt;
  logic [LineWords-1:0][WordWidth-1:0] lineBuf;

  // beats arrive lowest word first
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (clear_i) begin
      beatCnt <= '0;
    end else if (beatValid_i) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (beatValid_i) begin
      lineBuf[beatCnt] <= beatData_i;
    end
  end

  // high with the beat that completes the line
  assign lastBeat_o = beatValid_i && (beatCnt == CntWidth'(LineWords - 1));
  assign line_o     = lineBuf;

endmodule

// ==== rtl/tagStore.sv ====
module tagStore #(
  parameter int IndexWidth = 6
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  dcachePkg::reqAddr_u             addr_i,
  input  logic                            lookupEn_i,
  input  logic                            storeHit_i,
  input  logic                            fillEn_i,
  output logic                            hit_o,
  output logic                            hitWay_o,
  output logic                            victimWay_o,
  output logic                            victimDirty_o,
  output logic [dcachePkg::AddrWidth-1:0] victimAddr_o
);

  import dcachePkg::*;

  localparam int Sets = 2 ** IndexWidth;

  logic [TagWidth-1:0]     tagArr [2][Sets];
  logic [Sets-1:0][1:0]    validArr;
  logic [Sets-1:0][1:0]    dirtyArr;
  // way used most recently, per set
  logic [Sets-1:0]         lruArr;

  logic [IndexWidth-1:0]   idx;
  logic [1:0]              wayHit;
  reqAddr_u                victimAddr;

  assign idx = addr_i.fields.index;

  assign wayHit[0] = validArr[idx][0] && (tagArr[0][idx] == addr_i.fields.tag);
  assign wayHit[1] = validArr[idx][1] && (tagArr[1][idx] == addr_i.fields.tag);
  assign hit_o     = |wayHit;
  assign hitWay_o  = wayHit[1];

  // empty ways first, then the one not used last
  always_comb begin
    if (!validArr[idx][0]) begin
      victimWay_o = 1'b0;
    end else if (!validArr[idx][1]) begin
      victimWay_o = 1'b1;
    end else begin
      victimWay_o = ~lruArr[idx];
    end
  end

  assign victimDirty_o = validArr[idx][victimWay_o] && dirtyArr[idx][victimWay_o];

  // write-back address rebuilt from the stored tag
  always_comb begin
    victimAddr.fields.tag    = tagArr[victimWay_o][idx];
    victimAddr.fields.index  = idx;
    victimAddr.fields.offset = '0;
    victimAddr_o             = victimAddr.raw;
  end

  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      tagArr[victimWay_o][idx] <= addr_i.fields.tag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '0;
      dirtyArr <= '0;
      lruArr   <= '0;
    end else if (fillEn_i) begin
      // new line comes in clean
      validArr[idx][victimWay_o] <= 1'b1;
      dirtyArr[idx][victimWay_o] <= 1'b0;
      lruArr[idx]                <= victimWay_o;
    end else begin
      if (lookupEn_i && hit_o) begin
        lruArr[idx] <= hitWay_o;
      end
      if (storeHit_i) begin
        dirtyArr[idx][hitWay_o] <= 1'b1;
      end
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module dcacheTb -f project.f -o dcacheSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/dcacheSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== tests/dcacheTb.sv ====
module dcacheTb;

  import dcachePkg::*;

  localparam int NumEntries  = 21;
  localparam int RespTimeout = 200;

  localparam logic [1:0] OpLoad  = 2'd0;
  localparam logic [1:0] OpStore = 2'd1;
  localparam logic [1:0] OpReset = 2'd2;

  typedef struct packed {
    logic [1:0]           op;
    logic [AddrWidth-1:0] addr;
    logic [WordWidth-1:0] wdata;
    logic [MaskWidth-1:0] mask;
    logic                 expMiss;
    logic                 expWb;
    logic [AddrWidth-1:0] wbAddr;
  } stimEntry_t;

  logic                 clk = 1'b0;
  logic                 rst_n = 1'b0;
  logic                 reqValid = 1'b0;
  logic                 reqWrite = 1'b0;
  logic [AddrWidth-1:0] reqAddr = '0;
  logic [WordWidth-1:0] reqWData = '0;
  logic [MaskWidth-1:0] reqWMask = '0;
  logic                 memRdValid = 1'b0;
  logic [WordWidth-1:0] memRdData = '0;
  logic                 respValid;
  logic [WordWidth-1:0] respRData;
  logic                 memRdReq;
  logic [AddrWidth-1:0] memRdAddr;
  logic                 memWrReq;
  logic [AddrWidth-1:0] memWrAddr;
  logic [LineWidth-1:0] memWrLine;

  stimEntry_t           stimTable [NumEntries];
  // memory behind the cache and the data the requester should see
  logic [WordWidth-1:0] refMem    [logic [AddrWidth-1:0]];
  logic [WordWidth-1:0] goldenMem [logic [AddrWidth-1:0]];
  integer               seed = 26569;
  int                   errorCount = 0;
  int                   timeoutCount = 0;
  int                   rdReqCount = 0;
  int                   wrReqCount = 0;
  logic [AddrWidth-1:0] curAddr = '0;
  logic [AddrWidth-1:0] curWbAddr = '0;

  always #20 clk = ~clk;

  dcacheTop #(
    .IndexWidth (6)
  ) i_dcacheTop (
    .clk          (clk),
    .rst_n        (rst_n),
    .reqValid_i   (reqValid),
    .reqWrite_i   (reqWrite),
    .reqAddr_i    (reqAddr),
    .reqWData_i   (reqWData),
    .reqWMask_i   (reqWMask),
    .respValid_o  (respValid),
    .respRData_o  (respRData),
    .memRdReq_o   (memRdReq),
    .memRdAddr_o  (memRdAddr),
    .memRdValid_i (memRdValid),
    .memRdData_i  (memRdData),
    .memWrReq_o   (memWrReq),
    .memWrAddr_o  (memWrAddr),
    .memWrLine_o  (memWrLine)
  );

  // unwritten words read back as a function of their full address
  function automatic logic [WordWidth-1:0] fillPattern(input logic [AddrWidth-1:0] addr);
    return {addr ^ 32'hC3A5_5A3C, ~addr};
  endfunction

  function automatic logic [WordWidth-1:0] refWord(input logic [AddrWidth-1:0] addr);
    if (refMem.exists(addr)) begin
      return refMem[addr];
    end
    return fillPattern(addr);
  endfunction

  function automatic logic [WordWidth-1:0] goldenWord(input logic [AddrWidth-1:0] addr);
    if (goldenMem.exists(addr)) begin
      return goldenMem[addr];
    end
    return fillPattern(addr);
  endfunction

  task automatic checkValue(input string name, input logic [LineWidth-1:0] got,
                            input logic [LineWidth-1:0] exp);
    if (got !== exp) begin
      errorCount++;
      $display("** Error at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic mergeStore(input logic [AddrWidth-1:0] addr, input logic [WordWidth-1:0] data,
                            input logic [MaskWidth-1:0] mask);
    logic [WordWidth-1:0] word;
    word = goldenWord(addr);
    for (int b = 0; b < MaskWidth; b++) begin
      if (mask[b]) begin
        word[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    goldenMem[addr] = word;
  endtask

  // lines A, B, C and D at 0x060, 0x860, 0x1060 and 0x1860 all map to set 3
  task automatic buildTable();
    stimTable[0]  = '{OpLoad,  32'h0068, 64'h0, 8'h00, 1'b1, 1'b0, 32'h0};
    stimTable[1]  = '{OpLoad,  32'h0070, 64'h0, 8'h00, 1'b0, 1'b0, 32'h0};
    stimTable[2]  = '{OpLoad,  32'h0078, 64'h0, 8'h00, 1'b0, 1'b0, 32'h0};
    stimTable[3]  = '{OpLoad,  32'h0060, 64'h0, 8'h00, 1'b0, 1'b0, 32'h0};
    stimTable[4]  = '{OpStore, 32'h0068, 64'h1122_3344_5566_7788, 8'h0F, 1'b0, 1'b0, 32'h0};
    stimTable[5]  = '{OpLoad,  32'h0068, 64'h0, 8'h00, 1'b0, 1'b0, 32'h0};
    stimTable[6]  = '{OpLoad,  32'h0870, 64'h0, 8'h00, 1'b1, 1'b0, 32'h0};
    // A is least recent and dirty
    stimTable[7]  = '{OpLoad,  32'h1060, 64'h0, 8'h00, 1'b1, 1'b1, 32'h0060};
    stimTable[8]  = '{OpLoad,  32'h0068, 64'h0, 8'h00, 1'b1, 1'b0, 32'h0};
    stimTable[9]  = '{OpStore, 32'h1878, 64'hDEAD_BEEF_0BAD_F00D, 8'hF0, 1'b1, 1'b0, 32'h0};
    stimTable[10] = '{OpLoad,  32'h1878, 64'h0, 8'h00, 1'b0, 1'b0, 32'h0};
    stimTable[11] = '{OpStore, 32'h1878, 64'hCAFE_0000_0000_00AB, 8'h81, 1'b0, 1'b0, 32'h0};
    stimTable[12] = '{OpLoad,  32'h1068, 64'h0, 8'h00, 1'b1, 1'b0, 32'h0};
    stimTable[13] = '{OpLoad,  32'h0878, 64'h0, 8'h00, 1'b1, 1'b1, 32'h1860};
    stimTable[14] = '{OpLoad,  32'h1878, 64'h0, 8'h00, 1'b1, 1'b0, 32'h0};
    stimTable[15] = '{OpReset, 32'h0000, 64'h0, 8'h00, 1'b0, 1'b0, 32'h0};
    stimTable[16] = '{OpLoad,  32'h1878, 64'h0, 8'h00, 1'b1, 1'b0, 32'h0};
    stimTable[17] = '{OpLoad,  32'h0870, 64'h0, 8'h00, 1'b1, 1'b0, 32'h0};
    stimTable[18] = '{OpLoad,  32'h1870, 64'h0, 8'h00, 1'b0, 1'b0, 32'h0};
    // D was hit last so C replaces B
    stimTable[19] = '{OpLoad,  32'h1060, 64'h0, 8'h00, 1'b1, 1'b0, 32'h0};
    stimTable[20] = '{OpLoad,  32'h1868, 64'h0, 8'h00, 1'b0, 1'b0, 32'h0};
  endtask

  task automatic applyReset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic waitResponse(output logic timedOut, output int waited);
    int cycles;
    timedOut = 1'b1;
    cycles = 0;
    while (cycles < RespTimeout) begin
      @(negedge clk);
      if (respValid) begin
        timedOut = 1'b0;
        break;
      end
      cycles++;
    end
    waited = cycles;
  endtask

  task automatic absorbWriteBack();
    logic [LineWidth-1:0] expLine;
    for (int w = 0; w < LineWords; w++) begin
      expLine[w*WordWidth +: WordWidth] = goldenWord(memWrAddr + w * 8);
      refMem[memWrAddr + w * 8] = memWrLine[w*WordWidth +: WordWidth];
    end
    checkValue("memWrAddr_o", LineWidth'(memWrAddr), LineWidth'(curWbAddr));
    checkValue("memWrLine_o", memWrLine, expLine);
  endtask

  // four beats, lowest word first, with random gaps
  task automatic sendRefill(input logic [AddrWidth-1:0] base);
    int gap;
    for (int b = 0; b < LineWords; b++) begin
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) begin
        @(posedge clk);
        memRdValid <= 1'b0;
      end
      @(posedge clk);
      memRdValid <= 1'b1;
      memRdData  <= refWord(base + b * 8);
    end
    @(posedge clk);
    memRdValid <= 1'b0;
  endtask

  // memory model
  always begin
    @(negedge clk);
    if (memWrReq) begin
      wrReqCount++;
      absorbWriteBack();
    end
    if (memRdReq) begin
      rdReqCount++;
      checkValue("memRdAddr_o", LineWidth'(memRdAddr), LineWidth'(curAddr & 32'hFFFF_FFE0));
      sendRefill(memRdAddr);
    end
  end

  initial begin
    stimEntry_t e;
    int         rdBefore;
    int         wrBefore;
    logic       timedOut;
    int         waited;
    buildTable();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < NumEntries; i++) begin
      e = stimTable[i];
      if (e.op == OpReset) begin
        applyReset();
      end else begin
        @(posedge clk);
        rdBefore  = rdReqCount;
        wrBefore  = wrReqCount;
        curAddr   = e.addr;
        curWbAddr = e.wbAddr;
        reqValid <= 1'b1;
        reqWrite <= (e.op == OpStore);
        reqAddr  <= e.addr;
        reqWData <= e.wdata;
        reqWMask <= e.mask;
        @(posedge clk);
        reqValid <= 1'b0;
        waitResponse(timedOut, waited);
        if (timedOut) begin
          $display("no response to table entry %0d within %0d cycles", i, RespTimeout);
          timeoutCount++;
          break;
        end
        if (e.op == OpStore) begin
          mergeStore(e.addr & 32'hFFFF_FFF8, e.wdata, e.mask);
        end else begin
          checkValue("respRData_o", LineWidth'(respRData),
                     LineWidth'(goldenWord(e.addr & 32'hFFFF_FFF8)));
        end
        if (!e.expMiss) begin
          // a hit answers in the cycle after the request
          checkValue("respValid_o latency", LineWidth'(waited), LineWidth'(0));
        end
        checkValue("memRdReq_o count", LineWidth'(rdReqCount - rdBefore), LineWidth'(e.expMiss));
        checkValue("memWrReq_o count", LineWidth'(wrReqCount - wrBefore), LineWidth'(e.expWb));
      end
    end
    $display("errors: %0d mismatches, %0d timeouts", errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== tests/dcache_assertions.sv ====
module dcache_assertions (
  input logic clk,
  input logic rst_n,
  input logic respValid_i,
  input logic memRdReq_i,
  input logic memWrReq_i,
  input logic memRdValid_i,
  input logic fillEn_i
);

  // beats seen since the last refill request
  logic [2:0] beatCnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (memRdReq_i) begin
      beatCnt <= '0;
    end else if (memRdValid_i) begin
      beatCnt <= beatCnt + 3'd1;
    end
  end

  respSingleCycle: assert property (
    @(posedge clk) disable iff (!rst_n) respValid_i |=> !respValid_i
  ) else $error("respValid_o high for two cycles in a row");

  memReqExclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(memRdReq_i && memWrReq_i)
  ) else $error("memRdReq_o and memWrReq_o high together");

  // the fill follows the fourth beat and no other
  fourBeatsBeforeFill: assert property (
    @(posedge clk) disable iff (!rst_n) fillEn_i |-> beatCnt == 3'd4
  ) else $error("fill without exactly four refill beats");

endmodule

bind dcacheTop dcache_assertions i_dcacheAssertions (
  .clk          (clk),
  .rst_n        (rst_n),
  .respValid_i  (respValid_o),
  .memRdReq_i   (memRdReq_o),
  .memWrReq_i   (memWrReq_o),
  .memRdValid_i (memRdValid_i),
  .fillEn_i     (fillEn)
);
